// File: hdl/rnn_macros.svh
`ifndef RNN_MACROS_SVH
`define RNN_MACROS_SVH

// layer geometry
`define RNN_IN_SIZE 8
`define RNN_OUT_SIZE 4

// word widths
`define RNN_FIXED_W 32
`define RNN_WEIGHT_W 8

// Q16.16 fraction
`define RNN_FRAC_BITS 16

// weights are stored as value*256
`define RNN_SCALE_SHIFT 8

// tanh(k/8) for k = 0..32
`define RNN_TANH_ENTRIES 33

`define RNN_ONE 32'sh0001_0000
`define RNN_HALF 32'sh0000_8000

`endif

// File: hdl/rnn_pkg.sv
`default_nettype none
`include "rnn_macros.svh"

package rnn_pkg;

	typedef logic signed [`RNN_FIXED_W-1:0] fixed_t;
	typedef logic signed [`RNN_WEIGHT_W-1:0] weight_t;

	typedef enum logic [1:0] {
		ACT_TANH = 2'd0,
		ACT_SIGMOID = 2'd1,
		ACT_RELU = 2'd2
	} act_kind_e;

	typedef enum logic [1:0] {
		CFG_WEIGHT = 2'd0,
		CFG_BIAS = 2'd1,
		CFG_ACT = 2'd2
	} cfg_kind_e;

	// one configuration word, data[1:0] holds act_kind_e for CFG_ACT
	typedef struct packed {
		cfg_kind_e kind;
		logic [7:0] addr;
		weight_t data;
	} cfg_write_t;

	typedef struct packed {
		fixed_t data;
		logic last;
	} feat_beat_t;

	typedef struct packed {
		fixed_t value;
		logic [1:0] neuron;
		logic last;
	} result_t;

	// finished neuron sum on its way to the activation pipeline
	typedef struct packed {
		fixed_t sum;
		logic [1:0] neuron;
		logic last;
		act_kind_e act;
	} acc_beat_t;

endpackage

`default_nettype wire

// File: hdl/feature_buffer.sv
`timescale 1ns/1ps
`default_nettype none
`include "rnn_macros.svh"

module feature_buffer (
	input wire clk,
	input wire rst,
	input wire feat_valid_i,
	input wire rnn_pkg::feat_beat_t feat_i,
	output logic feat_ready_o,
	input wire [2:0] rd_idx_i,
	output rnn_pkg::fixed_t rd_data_o,
	output logic full_o,
	input wire release_i
);

	rnn_pkg::fixed_t vec_mem [`RNN_IN_SIZE];
	logic [2:0] fill_cnt;
	logic wr_en;

	// the beat count closes the vector, the last flag is not needed
	assign feat_ready_o = !full_o;
	assign wr_en = feat_valid_i && feat_ready_o;
	assign rd_data_o = vec_mem[rd_idx_i];

	always_ff @(posedge clk) begin
		if (rst) begin
			fill_cnt <= '0;
			full_o <= 1'b0;
		end else if (release_i) begin
			fill_cnt <= '0;
			full_o <= 1'b0;
		end else if (wr_en) begin
			fill_cnt <= fill_cnt + 3'd1;
			if (fill_cnt == 3'(`RNN_IN_SIZE - 1))
				full_o <= 1'b1;
		end
	end

	// vector storage
	always_ff @(posedge clk) begin
		if (wr_en)
			vec_mem[fill_cnt] <= feat_i.data;
	end

endmodule

`default_nettype wire

// File: hdl/weight_store.sv
`timescale 1ns/1ps
`default_nettype none
`include "rnn_macros.svh"

module weight_store (
	input wire clk,
	input wire rst,
	input wire cfg_valid_i,
	input wire rnn_pkg::cfg_write_t cfg_i,
	output logic cfg_ready_o,
	input wire idle_i,
	input wire [4:0] w_addr_i,
	output rnn_pkg::weight_t w_data_o,
	input wire [1:0] b_addr_i,
	output rnn_pkg::weight_t b_data_o,
	output rnn_pkg::act_kind_e act_kind_o
);

	// weight at input i for neuron n lives at i*OUT + n
	rnn_pkg::weight_t w_mem [`RNN_IN_SIZE * `RNN_OUT_SIZE];
	rnn_pkg::weight_t b_mem [`RNN_OUT_SIZE];
	logic cfg_fire;

	// writes only while no vector is in flight
	assign cfg_ready_o = idle_i;
	assign cfg_fire = cfg_valid_i && idle_i;

	assign w_data_o = w_mem[w_addr_i];
	assign b_data_o = b_mem[b_addr_i];

	always_ff @(posedge clk) begin
		if (cfg_fire && cfg_i.kind == rnn_pkg::CFG_WEIGHT)
			w_mem[cfg_i.addr[4:0]] <= cfg_i.data;
		if (cfg_fire && cfg_i.kind == rnn_pkg::CFG_BIAS)
			b_mem[cfg_i.addr[1:0]] <= cfg_i.data;
	end

	// activation kind, tanh out of reset
	always_ff @(posedge clk) begin
		if (rst)
			act_kind_o <= rnn_pkg::ACT_TANH;
		else if (cfg_fire && cfg_i.kind == rnn_pkg::CFG_ACT)
			act_kind_o <= rnn_pkg::act_kind_e'(cfg_i.data[1:0]);
	end

endmodule

`default_nettype wire

// File: hdl/dense_sequencer.sv
`timescale 1ns/1ps
`default_nettype none
`include "rnn_macros.svh"

module dense_sequencer (
	input wire clk,
	input wire rst,
	input wire start_i,
	output logic [2:0] feat_idx_o,
	input wire rnn_pkg::fixed_t feat_data_i,
	output logic [4:0] w_addr_o,
	input wire rnn_pkg::weight_t w_data_i,
	output logic [1:0] b_addr_o,
	input wire rnn_pkg::weight_t b_data_i,
	input wire rnn_pkg::act_kind_e act_kind_i,
	output logic acc_valid_o,
	output rnn_pkg::acc_beat_t acc_o,
	input wire acc_ready_i,
	output logic done_o
);

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_BIAS,
		SEQ_MAC,
		SEQ_OFFER
	} seq_state_e;

	seq_state_e state;
	logic [1:0] neuron;
	logic [2:0] in_idx;
	rnn_pkg::fixed_t acc;
	rnn_pkg::fixed_t product;
	logic last_neuron;
	logic take;

	assign feat_idx_o = in_idx;
	// i*4 + n, the neuron count is a power of two
	assign w_addr_o = {in_idx, neuron};
	assign b_addr_o = neuron;

	// integer weight times Q16.16 feature is already Q16.16
	assign product = rnn_pkg::fixed_t'(w_data_i) * feat_data_i;

	assign last_neuron = (neuron == 2'(`RNN_OUT_SIZE - 1));
	assign acc_valid_o = (state == SEQ_OFFER);
	assign take = acc_valid_o && acc_ready_i;
	assign done_o = take && last_neuron;

	always_comb begin
		acc_o.sum = acc;
		acc_o.neuron = neuron;
		acc_o.last = last_neuron;
		acc_o.act = act_kind_i;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= SEQ_IDLE;
			neuron <= '0;
			in_idx <= '0;
		end else begin
			case (state)
				SEQ_IDLE: begin
					neuron <= '0;
					in_idx <= '0;
					if (start_i)
						state <= SEQ_BIAS;
				end
				SEQ_BIAS: begin
					in_idx <= '0;
					state <= SEQ_MAC;
				end
				SEQ_MAC: begin
					in_idx <= in_idx + 3'd1;
					if (in_idx == 3'(`RNN_IN_SIZE - 1))
						state <= SEQ_OFFER;
				end
				SEQ_OFFER: begin
					// hold the sum until the activation pipeline takes it
					if (take) begin
						neuron <= neuron + 2'd1;
						state <= last_neuron ? SEQ_IDLE : SEQ_BIAS;
					end
				end
				default: state <= SEQ_IDLE;
			endcase
		end
	end

	// bias enters as an integer, shifted up to Q16.16
	always_ff @(posedge clk) begin
		if (state == SEQ_BIAS)
			acc <= rnn_pkg::fixed_t'(b_data_i) <<< `RNN_FRAC_BITS;
		else if (state == SEQ_MAC)
			acc <= acc + product;
	end

endmodule

`default_nettype wire

// File: hdl/activation_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "rnn_macros.svh"

module activation_unit (
	input wire clk,
	input wire rst,
	input wire acc_valid_i,
	input wire rnn_pkg::acc_beat_t acc_i,
	output logic acc_ready_o,
	output logic res_valid_o,
	output rnn_pkg::result_t res_o,
	input wire res_ready_i,
	output logic busy_o
);

	rnn_pkg::fixed_t tanh_rom [`RNN_TANH_ENTRIES];

	logic advance;
	rnn_pkg::fixed_t pre;
	rnn_pkg::fixed_t mag;
	logic sat;
	logic [5:0] seg;

	// stage one
	logic s1_valid;
	logic s1_neg;
	logic s1_sat;
	logic [12:0] s1_frac;
	rnn_pkg::fixed_t s1_pre;
	rnn_pkg::fixed_t s1_t0;
	rnn_pkg::fixed_t s1_t1;
	logic [1:0] s1_neuron;
	logic s1_last;
	rnn_pkg::act_kind_e s1_act;

	// stage two math
	rnn_pkg::fixed_t slope;
	rnn_pkg::fixed_t t_abs;
	rnn_pkg::fixed_t tanh_val;
	rnn_pkg::fixed_t act_val;

	initial $readmemh("tanh_table.mem", tanh_rom);

	// both stages move together, only a held result blocks them
	assign advance = !res_valid_o || res_ready_i;
	assign acc_ready_o = advance;
	assign busy_o = s1_valid || res_valid_o;

	assign pre = $signed(acc_i.sum) >>> `RNN_SCALE_SHIFT;
	assign mag = pre[`RNN_FIXED_W-1] ? -pre : pre;
	assign sat = (mag >= (`RNN_ONE <<< 2));
	// segment of 1/8 and the position inside it
	assign seg = sat ? 6'd0 : mag[18:13];

	assign slope = (s1_t1 - s1_t0) * rnn_pkg::fixed_t'({19'd0, s1_frac});
	assign t_abs = s1_sat ? `RNN_ONE : s1_t0 + (slope >>> 13);
	assign tanh_val = s1_neg ? -t_abs : t_abs;

	always_comb begin
		case (s1_act)
			rnn_pkg::ACT_SIGMOID: act_val = (tanh_val >>> 1) + `RNN_HALF;
			rnn_pkg::ACT_RELU: act_val = s1_neg ? '0 : s1_pre;
			default: act_val = tanh_val;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			s1_valid <= 1'b0;
			res_valid_o <= 1'b0;
		end else if (advance) begin
			s1_valid <= acc_valid_i;
			res_valid_o <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			s1_neg <= pre[`RNN_FIXED_W-1];
			s1_sat <= sat;
			s1_frac <= mag[12:0];
			s1_pre <= pre;
			s1_t0 <= tanh_rom[seg];
			s1_t1 <= tanh_rom[seg + 6'd1];
			s1_neuron <= acc_i.neuron;
			s1_last <= acc_i.last;
			s1_act <= acc_i.act;
			res_o.value <= act_val;
			res_o.neuron <= s1_neuron;
			res_o.last <= s1_last;
		end
	end

endmodule

`default_nettype wire

// File: hdl/dense_layer.sv
`timescale 1ns/1ps
`default_nettype none
`include "rnn_macros.svh"

module dense_layer (
	input wire clk,
	input wire rst,
	input wire cfg_valid_i,
	input wire rnn_pkg::cfg_write_t cfg_i,
	output logic cfg_ready_o,
	input wire feat_valid_i,
	input wire rnn_pkg::feat_beat_t feat_i,
	output logic feat_ready_o,
	output logic res_valid_o,
	output rnn_pkg::result_t res_o,
	input wire res_ready_i
);

	logic buf_valid;
	logic buf_ready;
	logic buf_full;
	logic [2:0] feat_idx;
	rnn_pkg::fixed_t feat_data;
	logic [4:0] w_addr;
	rnn_pkg::weight_t w_data;
	logic [1:0] b_addr;
	rnn_pkg::weight_t b_data;
	rnn_pkg::act_kind_e act_kind;
	logic acc_valid;
	logic acc_ready;
	rnn_pkg::acc_beat_t acc;
	logic seq_done;
	logic act_busy;
	logic idle;

	assign idle = !buf_full && !act_busy;

	// next vector waits until the last results have drained
	assign buf_valid = feat_valid_i && !act_busy;
	assign feat_ready_o = buf_ready && !act_busy;

	feature_buffer fbuf0 (
		.clk(clk),
		.rst(rst),
		.feat_valid_i(buf_valid),
		.feat_i(feat_i),
		.feat_ready_o(buf_ready),
		.rd_idx_i(feat_idx),
		.rd_data_o(feat_data),
		.full_o(buf_full),
		.release_i(seq_done)
	);

	weight_store wstore0 (
		.clk(clk),
		.rst(rst),
		.cfg_valid_i(cfg_valid_i),
		.cfg_i(cfg_i),
		.cfg_ready_o(cfg_ready_o),
		.idle_i(idle),
		.w_addr_i(w_addr),
		.w_data_o(w_data),
		.b_addr_i(b_addr),
		.b_data_o(b_data),
		.act_kind_o(act_kind)
	);

	dense_sequencer seq0 (
		.clk(clk),
		.rst(rst),
		.start_i(buf_full),
		.feat_idx_o(feat_idx),
		.feat_data_i(feat_data),
		.w_addr_o(w_addr),
		.w_data_i(w_data),
		.b_addr_o(b_addr),
		.b_data_i(b_data),
		.act_kind_i(act_kind),
		.acc_valid_o(acc_valid),
		.acc_o(acc),
		.acc_ready_i(acc_ready),
		.done_o(seq_done)
	);

	activation_unit act0 (
		.clk(clk),
		.rst(rst),
		.acc_valid_i(acc_valid),
		.acc_i(acc),
		.acc_ready_o(acc_ready),
		.res_valid_o(res_valid_o),
		.res_o(res_o),
		.res_ready_i(res_ready_i),
		.busy_o(act_busy)
	);

endmodule

`default_nettype wire

// File: testbench/dense_layer_checker.sv
`timescale 1ns/1ps
`default_nettype none
`include "rnn_macros.svh"

module dense_layer_checker (
	input wire clk,
	input wire rst,
	input wire cfg_valid_i,
	input wire cfg_ready_i,
	input wire feat_valid_i,
	input wire feat_ready_i,
	input wire res_valid_i,
	input wire rnn_pkg::result_t res_i,
	input wire res_ready_i
);

	int fail_count = 0;

	logic [2:0] beat_cnt;
	logic vec_busy;

	// a vector is in flight from its last feature beat to its last result
	always_ff @(posedge clk) begin
		if (rst) begin
			beat_cnt <= '0;
			vec_busy <= 1'b0;
		end else begin
			if (feat_valid_i && feat_ready_i) begin
				beat_cnt <= beat_cnt + 3'd1;
				if (beat_cnt == 3'(`RNN_IN_SIZE - 1))
					vec_busy <= 1'b1;
			end
			if (res_valid_i && res_ready_i && res_i.last)
				vec_busy <= 1'b0;
		end
	end

	// a stalled result keeps its value
	a_stall_hold: assert property (@(posedge clk) disable iff (rst)
		res_valid_i && !res_ready_i |=> res_valid_i && $stable(res_i))
	else begin
		$error("result changed while the output was stalled");
		fail_count++;
	end

	// no new features while results are pending
	a_no_feat_pending: assert property (@(posedge clk) disable iff (rst)
		vec_busy |-> !feat_ready_i)
	else begin
		$error("feature input ready while a result is pending");
		fail_count++;
	end

	// configuration only lands while the layer is idle
	a_cfg_idle: assert property (@(posedge clk) disable iff (rst)
		cfg_valid_i && cfg_ready_i |-> !vec_busy)
	else begin
		$error("configuration beat accepted while the layer was busy");
		fail_count++;
	end

endmodule

bind dense_layer dense_layer_checker chk0 (
	.clk(clk),
	.rst(rst),
	.cfg_valid_i(cfg_valid_i),
	.cfg_ready_i(cfg_ready_o),
	.feat_valid_i(feat_valid_i),
	.feat_ready_i(feat_ready_o),
	.res_valid_i(res_valid_o),
	.res_i(res_o),
	.res_ready_i(res_ready_i)
);

`default_nettype wire

// File: testbench/dense_layer_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "rnn_macros.svh"

module dense_layer_tb;

	localparam int TIMEOUT = 2000;

	logic clk;
	logic rst;
	logic cfg_valid_i;
	rnn_pkg::cfg_write_t cfg_i;
	logic cfg_ready_o;
	logic feat_valid_i;
	rnn_pkg::feat_beat_t feat_i;
	logic feat_ready_o;
	logic res_valid_o;
	rnn_pkg::result_t res_o;
	logic res_ready_i;

	// copy of what has been written into the DUT
	rnn_pkg::weight_t w_ref [`RNN_IN_SIZE * `RNN_OUT_SIZE];
	rnn_pkg::weight_t b_ref [`RNN_OUT_SIZE];
	rnn_pkg::act_kind_e act_ref;
	rnn_pkg::fixed_t tanh_ref [`RNN_TANH_ENTRIES];
	rnn_pkg::fixed_t x_vec [`RNN_IN_SIZE];

	rnn_pkg::result_t want_q [$];
	int pushed_results;
	int accepted_results;
	int vectors_sent;
	logic random_ready;

	dense_layer dut0 (
		.clk(clk),
		.rst(rst),
		.cfg_valid_i(cfg_valid_i),
		.cfg_i(cfg_i),
		.cfg_ready_o(cfg_ready_o),
		.feat_valid_i(feat_valid_i),
		.feat_i(feat_i),
		.feat_ready_o(feat_ready_o),
		.res_valid_o(res_valid_o),
		.res_o(res_o),
		.res_ready_i(res_ready_i)
	);

	always #5 clk = ~clk;

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Test failures found");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_value(input string name, input rnn_pkg::fixed_t got,
			input rnn_pkg::fixed_t want);
		if (got !== want)
			fail_run($sformatf("mismatch at %0t: %s expected 0x%08h got 0x%08h",
				$time, name, want, got));
	endtask

	task automatic check_index(input string name, input logic [1:0] got_n, input logic got_last,
			input logic [1:0] want_n, input logic want_last);
		if ({got_n, got_last} !== {want_n, want_last})
			fail_run($sformatf("mismatch at %0t: %s expected %0d/%0b got %0d/%0b",
				$time, name, want_n, want_last, got_n, got_last));
	endtask

	// table tanh, then sigmoid or rectifier on top
	function automatic rnn_pkg::fixed_t ref_activate(input int pre,
			input rnn_pkg::act_kind_e kind);
		int a;
		int k;
		int f;
		int t;
		int th;
		a = (pre < 0) ? -pre : pre;
		if (a >= 4 * `RNN_ONE) begin
			t = `RNN_ONE;
		end else begin
			k = a / 8192;
			f = a % 8192;
			t = tanh_ref[k] + (((tanh_ref[k + 1] - tanh_ref[k]) * f) >>> 13);
		end
		th = (pre < 0) ? -t : t;
		case (kind)
			rnn_pkg::ACT_SIGMOID: return (th >>> 1) + `RNN_HALF;
			rnn_pkg::ACT_RELU: return (pre < 0) ? 0 : pre;
			default: return th;
		endcase
	endfunction

	function automatic rnn_pkg::fixed_t ref_neuron(input int n);
		int acc;
		acc = int'(b_ref[n]) * 65536;
		for (int i = 0; i < `RNN_IN_SIZE; i++)
			acc += int'(w_ref[i * `RNN_OUT_SIZE + n]) * int'(x_vec[i]);
		return ref_activate(acc >>> `RNN_SCALE_SHIFT, act_ref);
	endfunction

	function automatic rnn_pkg::weight_t rand_weight();
		return rnn_pkg::weight_t'(int'($urandom_range(63)) - 32);
	endfunction

	// all calls start and end 1 ns after a rising edge
	task automatic send_cfg(input rnn_pkg::cfg_kind_e kind, input int addr,
			input rnn_pkg::weight_t data);
		int waited;
		waited = 0;
		cfg_valid_i = 1'b1;
		cfg_i.kind = kind;
		cfg_i.addr = 8'(addr);
		cfg_i.data = data;
		while (!cfg_ready_o) begin
			@(posedge clk);
			#1;
			waited++;
			if (waited > TIMEOUT)
				fail_run("timeout: configuration port never became ready");
		end
		@(posedge clk);
		#1;
		cfg_valid_i = 1'b0;
	endtask

	task automatic write_weight(input int i, input int n, input rnn_pkg::weight_t w);
		send_cfg(rnn_pkg::CFG_WEIGHT, i * `RNN_OUT_SIZE + n, w);
		w_ref[i * `RNN_OUT_SIZE + n] = w;
	endtask

	task automatic write_bias(input int n, input rnn_pkg::weight_t b);
		send_cfg(rnn_pkg::CFG_BIAS, n, b);
		b_ref[n] = b;
	endtask

	task automatic write_act(input rnn_pkg::act_kind_e kind);
		send_cfg(rnn_pkg::CFG_ACT, 0, rnn_pkg::weight_t'(kind));
		act_ref = kind;
	endtask

	task automatic load_random_config();
		for (int i = 0; i < `RNN_IN_SIZE; i++)
			for (int n = 0; n < `RNN_OUT_SIZE; n++)
				write_weight(i, n, rand_weight());
		for (int n = 0; n < `RNN_OUT_SIZE; n++)
			write_bias(n, rand_weight());
	endtask

	// neurons 0 and 1 driven far positive, 2 and 3 far negative
	task automatic load_large_config();
		for (int i = 0; i < `RNN_IN_SIZE; i++)
			for (int n = 0; n < `RNN_OUT_SIZE; n++)
				write_weight(i, n, (n < 2) ? 8'sd100 + 8'($urandom_range(27))
					: -8'sd100 - 8'($urandom_range(28)));
		for (int n = 0; n < `RNN_OUT_SIZE; n++)
			write_bias(n, (n < 2) ? 8'sd127 : -8'sd128);
	endtask

	task automatic send_vector(input logic positive_only);
		int waited;
		rnn_pkg::result_t want_beat;
		for (int i = 0; i < `RNN_IN_SIZE; i++)
			x_vec[i] = positive_only ? int'($urandom_range(131072, 81920))
				: int'($urandom_range(262144)) - 131072;
		for (int n = 0; n < `RNN_OUT_SIZE; n++) begin
			want_beat.value = ref_neuron(n);
			want_beat.neuron = 2'(n);
			want_beat.last = (n == `RNN_OUT_SIZE - 1);
			want_q.push_back(want_beat);
			pushed_results++;
		end
		for (int i = 0; i < `RNN_IN_SIZE; i++) begin
			feat_valid_i = 1'b1;
			feat_i.data = x_vec[i];
			feat_i.last = (i == `RNN_IN_SIZE - 1);
			waited = 0;
			while (!feat_ready_o) begin
				@(posedge clk);
				#1;
				waited++;
				if (waited > TIMEOUT)
					fail_run("timeout: feature input never became ready");
			end
			if (i == 0 && accepted_results != vectors_sent * `RNN_OUT_SIZE)
				fail_run("feature input ready before the previous vector finished");
			@(posedge clk);
			#1;
		end
		feat_valid_i = 1'b0;
		vectors_sent++;
		if (feat_ready_o)
			fail_run("feature input still ready after a complete vector");
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (accepted_results != pushed_results) begin
			@(posedge clk);
			#1;
			waited++;
			if (waited > TIMEOUT)
				fail_run("timeout: expected results never arrived");
		end
	endtask

	// compare process, results accepted at the next edge
	initial begin : compare_results
		rnn_pkg::result_t want_beat;
		forever begin
			@(posedge clk);
			#1;
			res_ready_i = random_ready ? 1'($urandom_range(1)) : 1'b1;
			if (dut0.chk0.fail_count != 0)
				fail_run("an assertion in the bound checker failed");
			if (!rst && res_valid_o && res_ready_i) begin
				if (want_q.size() == 0)
					fail_run("result received while none was expected");
				want_beat = want_q.pop_front();
				check_value("res_o.value", res_o.value, want_beat.value);
				check_index("res_o.neuron/last", res_o.neuron, res_o.last,
					want_beat.neuron, want_beat.last);
				accepted_results++;
			end
		end
	end

	initial begin : main_flow
		clk = 1'b0;
		rst = 1'b1;
		cfg_valid_i = 1'b0;
		cfg_i = '0;
		feat_valid_i = 1'b0;
		feat_i = '0;
		res_ready_i = 1'b0;
		random_ready = 1'b0;
		pushed_results = 0;
		accepted_results = 0;
		vectors_sent = 0;
		act_ref = rnn_pkg::ACT_TANH;
		void'($urandom(52));
		$readmemh("tanh_table.mem", tanh_ref);
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;
		if (!feat_ready_o || !cfg_ready_o || res_valid_o)
			fail_run("handshake levels after reset are wrong");

		// tanh out of reset on random weights
		load_random_config();
		send_vector(1'b0);
		wait_drain();

		// sigmoid and rectifier on fresh vectors
		write_act(rnn_pkg::ACT_SIGMOID);
		send_vector(1'b0);
		wait_drain();
		write_act(rnn_pkg::ACT_RELU);
		send_vector(1'b0);
		wait_drain();

		// saturation
		load_large_config();
		write_act(rnn_pkg::ACT_TANH);
		send_vector(1'b1);
		wait_drain();
		write_act(rnn_pkg::ACT_SIGMOID);
		send_vector(1'b1);
		wait_drain();

		// random back-pressure on the result stream
		load_random_config();
		write_act(rnn_pkg::ACT_TANH);
		random_ready = 1'b1;
		repeat (3) send_vector(1'b0);
		wait_drain();
		random_ready = 1'b0;

		// back to back vectors, same configuration
		write_act(rnn_pkg::ACT_SIGMOID);
		repeat (3) send_vector(1'b0);
		wait_drain();

		@(posedge clk);
		#1;
		if (dut0.chk0.fail_count == 0 && want_q.size() == 0) begin
			$display("All tests passed!");
			$finish;
		end else begin
			$display("checker failures %0d, results left %0d",
				dut0.chk0.fail_count, want_q.size());
			$display("Test failures found");
			$fatal(1, "run ended with errors");
		end
	end

endmodule

`default_nettype wire

// File: tanh_table.mem
// tanh(k/8) for k = 0..32, one Q16.16 word per line
00000000
00001FD6
00003EB3
00005BBD
0000764D
00008DFA
0000A299
0000B433
0000C2F8
0000CF2E
0000D929
0000E13C
0000E7B8
0000ECE3
0000F0FE
0000F43C
0000F6CB
0000F8CD
0000FA60
0000FB9C
0000FC93
0000FD54
0000FDEB
0000FE60
0000FEBC
0000FF03
0000FF3B
0000FF67
0000FF89
0000FFA3
0000FFB8
0000FFC8
0000FFD4

// File: compile.f
+incdir+hdl
hdl/rnn_pkg.sv
hdl/feature_buffer.sv
hdl/weight_store.sv
hdl/dense_sequencer.sv
hdl/activation_unit.sv
hdl/dense_layer.sv
testbench/dense_layer_checker.sv
testbench/dense_layer_tb.sv
